// File: hw/memSelfTestConsts.svh
`ifndef MEM_SELF_TEST_CONSTS_SVH
`define MEM_SELF_TEST_CONSTS_SVH

// byte address width
`define MEM_ADDR_W 26

// data path
`define MEM_DATA_W 32
`define MEM_LANES 4

// word store depth, word addresses wrap modulo this
`define STORE_WORDS 4096

// self-test program length
`define TEST_STEPS 16

`endif

// File: hw/memBusPkg.sv
`default_nettype none

`include "memSelfTestConsts.svh"

package memBusPkg;

  typedef logic [`MEM_ADDR_W-1:0] byteAddrT;
  typedef logic [`MEM_DATA_W-1:0] wordT;
  typedef logic [`MEM_LANES-1:0] laneMaskT;
  typedef logic [$clog2(`STORE_WORDS)-1:0] wordAddrT;

  // travels with a read so the aligner can rebuild the byte result
  typedef struct packed {
    logic [$clog2(`MEM_LANES)-1:0] offset;
    logic split;
    laneMaskT lanes;
  } readTagT;

endpackage

`default_nettype wire

// File: hw/selfTestPkg.sv
`default_nettype none

`include "memSelfTestConsts.svh"

package selfTestPkg;

  import memBusPkg::*;

  typedef enum logic [1:0] {
    stepWrite,
    stepRead,
    stepEnd
  } stepKindT;

  typedef struct packed {
    stepKindT kind;
    byteAddrT addr;
    wordT data;
    laneMaskT be;
    wordT expected;
    wordT cmpMask;
  } testStepT;

  typedef logic [$clog2(`TEST_STEPS)-1:0] stepIndexT;

endpackage

`default_nettype wire

// File: hw/memWordIf.sv
`default_nettype none

interface memWordIf
  import memBusPkg::*;
();

  // word request side
  logic wordReq;
  logic wordWe;
  wordAddrT wordAddr;
  wordT wordData;
  laneMaskT wordBe;
  readTagT tag;

  // read return side
  wordT rdData;
  logic rdStrobe;
  readTagT rdTag;

  modport splitter (
    output wordReq, wordWe, wordAddr, wordData, wordBe, tag
  );

  modport store (
    input wordReq, wordWe, wordAddr, wordData, wordBe, tag,
    output rdData, rdStrobe, rdTag
  );

  modport aligner (
    input rdData, rdStrobe, rdTag
  );

endinterface

`default_nettype wire

// File: hw/selfTestSequencer.sv
`default_nettype none

module selfTestSequencer
  import memBusPkg::*;
  import selfTestPkg::*;
(
  input logic clk,
  input logic reset,
  input logic hostReq,
  input logic hostWe,
  input byteAddrT hostAddr,
  input wordT hostData,
  input laneMaskT hostBe,
  output logic hostAck,
  output logic req,
  output logic we,
  output byteAddrT addr,
  output wordT data,
  output laneMaskT bwe,
  input logic ack,
  input wordT q,
  input logic valid,
  output logic testDone,
  output logic testPass,
  output stepIndexT failStep
);

  typedef enum logic [1:0] {
    seqIssue,
    seqWait,
    seqDone
  } seqStateT;

  seqStateT state;
  stepIndexT stepIdx;
  testStepT step;
  logic mismatch;

  // kind, address, data, lanes, expected, compare mask
  function automatic testStepT programStep(input stepIndexT idx);
    testStepT s;
    case (idx)
      4'd0: s = '{stepWrite, 26'h0000100, 32'h01234567, 4'hF, 32'h0, 32'h0};
      4'd1: s = '{stepRead, 26'h0000100, 32'h0, 4'hF, 32'h01234567, 32'hFFFFFFFF};
      // single top lane, read back through lane 0
      4'd2: s = '{stepWrite, 26'h0000104, 32'hF0F0F0F0, 4'h8, 32'h0, 32'h0};
      4'd3: s = '{stepRead, 26'h0000107, 32'h0, 4'h1, 32'h000000F0, 32'hFFFFFFFF};
      // overlapping writes to one word
      4'd4: s = '{stepWrite, 26'h0000200, 32'hFEEDBADE, 4'hF, 32'h0, 32'h0};
      4'd5: s = '{stepWrite, 26'h0000200, 32'hFFFFBEEF, 4'h3, 32'h0, 32'h0};
      4'd6: s = '{stepRead, 26'h0000200, 32'h0, 4'hF, 32'hFEEDBEEF, 32'hFFFFFFFF};
      4'd7: s = '{stepRead, 26'h0000202, 32'h0, 4'h3, 32'h0000FEED, 32'hFFFFFFFF};
      // unaligned, crossing word boundaries
      4'd8: s = '{stepWrite, 26'h0000305, 32'h01234567, 4'hF, 32'h0, 32'h0};
      4'd9: s = '{stepWrite, 26'h0000309, 32'h89ABCDEF, 4'hF, 32'h0, 32'h0};
      4'd10: s = '{stepRead, 26'h0000308, 32'h0, 4'hF, 32'hABCDEF01, 32'hFFFFFFFF};
      4'd11: s = '{stepRead, 26'h0000307, 32'h0, 4'hF, 32'hCDEF0123, 32'hFFFFFFFF};
      4'd12: s = '{stepWrite, 26'h0000306, 32'h11223344, 4'hC, 32'h0, 32'h0};
      4'd13: s = '{stepRead, 26'h0000306, 32'h0, 4'hF, 32'h11222345, 32'hFFFFFFFF};
      4'd14: s = '{stepRead, 26'h0000309, 32'h0, 4'h6, 32'h00ABCD00, 32'h00FFFF00};
      default: s = '{stepEnd, 26'h0, 32'h0, 4'h0, 32'h0, 32'h0};
    endcase
    return s;
  endfunction

  assign step = programStep(stepIdx);
  assign mismatch = |((q ^ step.expected) & step.cmpMask);

  // port goes to the host once the program is over
  always_comb begin
    req = 1'b0;
    we = 1'b0;
    addr = step.addr;
    data = step.data;
    bwe = step.be;
    hostAck = 1'b0;
    if (state == seqDone) begin
      req = hostReq;
      we = hostWe;
      addr = hostAddr;
      data = hostData;
      bwe = hostBe;
      hostAck = ack;
    end else if (state == seqIssue && step.kind != stepEnd) begin
      req = 1'b1;
      we = (step.kind == stepWrite);
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= seqIssue;
      stepIdx <= '0;
      testDone <= 1'b0;
      testPass <= 1'b0;
      failStep <= '0;
    end else begin
      case (state)
        seqIssue: begin
          if (step.kind == stepEnd) begin
            state <= seqDone;
            testDone <= 1'b1;
            testPass <= 1'b1;
          end else if (ack) begin
            if (step.kind == stepRead) begin
              state <= seqWait;
            end else begin
              stepIdx <= stepIdx + 1'b1;
            end
          end
        end
        seqWait: begin
          if (valid) begin
            if (mismatch) begin
              // stop on the first bad read, pass stays low
              state <= seqDone;
              testDone <= 1'b1;
              failStep <= stepIdx;
            end else begin
              state <= seqIssue;
              stepIdx <= stepIdx + 1'b1;
            end
          end
        end
        default: begin
        end
      endcase
    end
  end

  reqHeldUntilAck: assert property (@(posedge clk) disable iff (reset) req && !ack |=> req);

endmodule

`default_nettype wire

// File: hw/unalignedSplitter.sv
`default_nettype none

`include "memSelfTestConsts.svh"

module unalignedSplitter
  import memBusPkg::*;
(
  input logic clk,
  input logic reset,
  input logic req,
  input logic we,
  input byteAddrT addr,
  input wordT data,
  input laneMaskT bwe,
  output logic ack,
  input logic valid,
  memWordIf.splitter wordBus
);

  logic [$clog2(`MEM_LANES)-1:0] offset;
  logic [2*`MEM_DATA_W-1:0] wideData;
  logic [2*`MEM_LANES-1:0] wideBe;
  wordAddrT baseWord;
  logic crosses;
  logic canIssue;
  logic secondPhase;
  logic readBusy;

  assign offset = addr[$clog2(`MEM_LANES)-1:0];
  assign baseWord = addr[$bits(wordAddrT)+1:2];

  // lane i goes to word position offset+i and may spill into the next word
  assign wideData = {{`MEM_DATA_W{1'b0}}, data} << {offset, 3'b000};
  assign wideBe = {{`MEM_LANES{1'b0}}, bwe} << offset;
  assign crosses = |wideBe[2*`MEM_LANES-1:`MEM_LANES];

  // a read is outstanding until the aligner strobes valid
  assign canIssue = req && !(readBusy && !valid);

  assign wordBus.wordReq = canIssue;
  assign wordBus.wordWe = we;
  assign wordBus.wordAddr = secondPhase ? baseWord + 1'b1 : baseWord;
  assign wordBus.wordData = secondPhase ? wideData[2*`MEM_DATA_W-1:`MEM_DATA_W]
                                        : wideData[`MEM_DATA_W-1:0];
  assign wordBus.wordBe = secondPhase ? wideBe[2*`MEM_LANES-1:`MEM_LANES]
                                      : wideBe[`MEM_LANES-1:0];
  assign wordBus.tag = '{offset: offset, split: crosses, lanes: bwe};

  // split access acks with its second word
  assign ack = canIssue && (secondPhase || !crosses);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      secondPhase <= 1'b0;
      readBusy <= 1'b0;
    end else begin
      secondPhase <= canIssue && crosses && !secondPhase;
      if (ack && !we) begin
        readBusy <= 1'b1;
      end else if (valid) begin
        readBusy <= 1'b0;
      end
    end
  end

  noReqWhileReadPending: assert property (
    @(posedge clk) disable iff (reset) ack && !we |=> !wordBus.wordReq
  );

endmodule

`default_nettype wire

// File: hw/wordStore.sv
`default_nettype none

`include "memSelfTestConsts.svh"

module wordStore
  import memBusPkg::*;
(
  input logic clk,
  input logic reset,
  memWordIf.store wordBus
);

  wordT mem [`STORE_WORDS];

  always_ff @(posedge clk) begin
    if (wordBus.wordReq) begin
      if (wordBus.wordWe) begin
        for (int i = 0; i < `MEM_LANES; i++) begin
          if (wordBus.wordBe[i]) begin
            mem[wordBus.wordAddr][8*i +: 8] <= wordBus.wordData[8*i +: 8];
          end
        end
      end else begin
        wordBus.rdData <= mem[wordBus.wordAddr];
        wordBus.rdTag <= wordBus.tag;
      end
    end
  end

  // one strobe per read word
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wordBus.rdStrobe <= 1'b0;
    end else begin
      wordBus.rdStrobe <= wordBus.wordReq && !wordBus.wordWe;
    end
  end

endmodule

`default_nettype wire

// File: hw/readAligner.sv
`default_nettype none

`include "memSelfTestConsts.svh"

module readAligner
  import memBusPkg::*;
(
  input logic clk,
  input logic reset,
  memWordIf.aligner wordBus,
  output wordT q,
  output logic valid
);

  logic haveFirst;
  wordT firstWord;
  logic [2*`MEM_DATA_W-1:0] wide;
  logic [2*`MEM_DATA_W-1:0] shifted;
  wordT merged;
  logic finish;

  // unsplit reads never use the upper word for enabled lanes
  assign wide = wordBus.rdTag.split ? {wordBus.rdData, firstWord}
                                    : {wordBus.rdData, wordBus.rdData};
  assign shifted = wide >> {wordBus.rdTag.offset, 3'b000};

  always_comb begin
    for (int i = 0; i < `MEM_LANES; i++) begin
      merged[8*i +: 8] = wordBus.rdTag.lanes[i] ? shifted[8*i +: 8] : 8'h00;
    end
  end

  assign finish = wordBus.rdStrobe && (!wordBus.rdTag.split || haveFirst);

  always_ff @(posedge clk) begin
    if (wordBus.rdStrobe && wordBus.rdTag.split && !haveFirst) begin
      firstWord <= wordBus.rdData;
    end
    if (finish) begin
      q <= merged;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      haveFirst <= 1'b0;
      valid <= 1'b0;
    end else begin
      valid <= finish;
      if (wordBus.rdStrobe && wordBus.rdTag.split) begin
        haveFirst <= !haveFirst;
      end
    end
  end

  validSingleCycle: assert property (@(posedge clk) disable iff (reset) valid |=> !valid);

endmodule

`default_nettype wire

// File: hw/memSelfTest.sv
`default_nettype none

module memSelfTest
  import memBusPkg::*;
  import selfTestPkg::*;
(
  input logic clk,
  input logic reset,
  input logic hostReq,
  input logic hostWe,
  input byteAddrT hostAddr,
  input wordT hostData,
  input laneMaskT hostBe,
  output logic hostAck,
  output wordT hostQ,
  output logic hostValid,
  output logic testDone,
  output logic testPass,
  output stepIndexT failStep
);

  logic req;
  logic we;
  byteAddrT addr;
  wordT data;
  laneMaskT bwe;
  logic ack;

  memWordIf wordBus ();

  // read data returns to both the sequencer and the host
  selfTestSequencer sequencer (
    .clk(clk),
    .reset(reset),
    .hostReq(hostReq),
    .hostWe(hostWe),
    .hostAddr(hostAddr),
    .hostData(hostData),
    .hostBe(hostBe),
    .hostAck(hostAck),
    .req(req),
    .we(we),
    .addr(addr),
    .data(data),
    .bwe(bwe),
    .ack(ack),
    .q(hostQ),
    .valid(hostValid),
    .testDone(testDone),
    .testPass(testPass),
    .failStep(failStep)
  );

  unalignedSplitter splitter (
    .clk(clk),
    .reset(reset),
    .req(req),
    .we(we),
    .addr(addr),
    .data(data),
    .bwe(bwe),
    .ack(ack),
    .valid(hostValid),
    .wordBus(wordBus.splitter)
  );

  wordStore store (
    .clk(clk),
    .reset(reset),
    .wordBus(wordBus.store)
  );

  readAligner aligner (
    .clk(clk),
    .reset(reset),
    .wordBus(wordBus.aligner),
    .q(hostQ),
    .valid(hostValid)
  );

endmodule

`default_nettype wire

// File: verification/memSelfTestTb.sv
`default_nettype none

`include "memSelfTestConsts.svh"

module memSelfTestTb
  import memBusPkg::*;
  import selfTestPkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int StoreBytes = `STORE_WORDS * `MEM_LANES;
  // held read, aligned pairs, unaligned triples, partial quads, alias pairs
  localparam int HostOps = 1 + 2 * 12 + 3 * 10 + 4 * 8 + 2 * 8;
  localparam int CycleLimit = 8 * (`TEST_STEPS + HostOps) + 200;

  logic clk;
  logic reset;
  logic hostReq;
  logic hostWe;
  byteAddrT hostAddr;
  wordT hostData;
  laneMaskT hostBe;
  logic hostAck;
  wordT hostQ;
  logic hostValid;
  logic testDone;
  logic testPass;
  stepIndexT failStep;

  logic [7:0] model [StoreBytes];
  int cycleCount = 0;

  memSelfTest dut0 (
    .clk(clk),
    .reset(reset),
    .hostReq(hostReq),
    .hostWe(hostWe),
    .hostAddr(hostAddr),
    .hostData(hostData),
    .hostBe(hostBe),
    .hostAck(hostAck),
    .hostQ(hostQ),
    .hostValid(hostValid),
    .testDone(testDone),
    .testPass(testPass),
    .failStep(failStep)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic reportFailure(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "stopping at first error");
  endtask

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      reportFailure($sformatf("run did not finish within %0d cycles", CycleLimit));
    end
  end

  task automatic checkWord(input string name, input wordT expected, input wordT actual);
    if (actual !== expected) begin
      reportFailure($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic checkFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      reportFailure($sformatf("mismatch %s expected %b actual %b", name, expected, actual));
    end
  endtask

  task automatic checkStepIndex(input string name, input stepIndexT expected,
                                input stepIndexT actual);
    if (actual !== expected) begin
      reportFailure($sformatf("mismatch %s expected %0d actual %0d", name, expected, actual));
    end
  endtask

  // byte i of an access lands at addr+i wrapped to the store size
  function automatic int byteIndex(input byteAddrT a, input int i);
    return (int'(a) + i) % StoreBytes;
  endfunction

  task automatic modelWrite(input byteAddrT a, input wordT d, input laneMaskT be);
    for (int i = 0; i < `MEM_LANES; i++) begin
      if (be[i]) begin
        model[byteIndex(a, i)] = d[8*i +: 8];
      end
    end
  endtask

  function automatic wordT modelRead(input byteAddrT a, input laneMaskT be);
    wordT r;
    for (int i = 0; i < `MEM_LANES; i++) begin
      r[8*i +: 8] = be[i] ? model[byteIndex(a, i)] : 8'h00;
    end
    return r;
  endfunction

  // write steps of the self-test program
  task automatic applySelfTestWrites();
    modelWrite(26'h0000100, 32'h01234567, 4'hF);
    modelWrite(26'h0000104, 32'hF0F0F0F0, 4'h8);
    modelWrite(26'h0000200, 32'hFEEDBADE, 4'hF);
    modelWrite(26'h0000200, 32'hFFFFBEEF, 4'h3);
    modelWrite(26'h0000305, 32'h01234567, 4'hF);
    modelWrite(26'h0000309, 32'h89ABCDEF, 4'hF);
    modelWrite(26'h0000306, 32'h11223344, 4'hC);
  endtask

  task automatic startAccess(input logic w, input byteAddrT a, input wordT d,
                             input laneMaskT be);
    @(posedge clk);
    #1;
    hostReq = 1'b1;
    hostWe = w;
    hostAddr = a;
    hostData = d;
    hostBe = be;
  endtask

  // called at a negedge and drops the request right after the ack cycle
  task automatic awaitAck();
    while (!hostAck) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    hostReq = 1'b0;
  endtask

  task automatic finishRead(input string name, input byteAddrT a, input laneMaskT be);
    awaitAck();
    @(negedge clk);
    checkFlag({name, " valid one cycle after ack"}, 1'b0, hostValid);
    @(negedge clk);
    checkFlag({name, " valid two cycles after ack"}, 1'b1, hostValid);
    checkWord(name, modelRead(a, be), hostQ);
  endtask

  task automatic hostWrite(input byteAddrT a, input wordT d, input laneMaskT be);
    startAccess(1'b1, a, d, be);
    @(negedge clk);
    awaitAck();
    modelWrite(a, d, be);
  endtask

  task automatic hostRead(input string name, input byteAddrT a, input laneMaskT be);
    startAccess(1'b0, a, 32'h0, be);
    @(negedge clk);
    finishRead(name, a, be);
  endtask

  function automatic byteAddrT randomAddr();
    return byteAddrT'($urandom % StoreBytes);
  endfunction

  initial begin
    byteAddrT a;
    byteAddrT aliasAddr;
    wordT d;
    laneMaskT be;
    byteAddrT alignedAddrs [$];

    void'($urandom(32'hcd3dd80a));
    // host read of the first program word is held from reset on
    reset = 1'b1;
    hostReq = 1'b1;
    hostWe = 1'b0;
    hostAddr = 26'h0000100;
    hostData = 32'h0;
    hostBe = 4'hF;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    @(negedge clk);
    while (!testDone) begin
      checkFlag("hostAck during self-test", 1'b0, hostAck);
      @(negedge clk);
    end
    checkFlag("self-test pass", 1'b1, testPass);
    checkStepIndex("self-test failStep", '0, failStep);
    applySelfTestWrites();
    finishRead("held read after self-test", 26'h0000100, 4'hF);

    // aligned full words
    for (int i = 0; i < 12; i++) begin
      a = randomAddr();
      a[1:0] = 2'b00;
      alignedAddrs.push_back(a);
      hostWrite(a, $urandom, 4'hF);
    end
    foreach (alignedAddrs[i]) begin
      hostRead($sformatf("aligned read %0d", i), alignedAddrs[i], 4'hF);
    end

    // unaligned accesses where the first wraps past the top of the store
    for (int i = 0; i < 10; i++) begin
      a = (i == 0) ? byteAddrT'(StoreBytes - 2) : randomAddr();
      if (a[1:0] == 2'b00) begin
        a[1:0] = 2'b01 + 2'($urandom % 3);
      end
      hostWrite(a, $urandom, 4'hF);
      hostRead($sformatf("unaligned read %0d", i), a, 4'hF);
      hostRead($sformatf("shifted read %0d", i), a + 1'b1, 4'h7);
    end

    // partial lanes
    for (int i = 0; i < 8; i++) begin
      a = randomAddr();
      hostWrite(a, $urandom, 4'hF);
      be = laneMaskT'(1 + $urandom % 14);
      hostWrite(a, $urandom, be);
      hostRead($sformatf("after partial write %0d", i), a, 4'hF);
      be = laneMaskT'(1 + $urandom % 14);
      hostRead($sformatf("partial read %0d", i), a, be);
    end

    // addresses a store size apart hit the same bytes
    for (int i = 0; i < 8; i++) begin
      a = randomAddr();
      aliasAddr = a + byteAddrT'(StoreBytes * (1 + $urandom % 4095));
      d = $urandom;
      if (i % 2 == 0) begin
        hostWrite(aliasAddr, d, 4'hF);
        hostRead($sformatf("alias read low %0d", i), a, 4'hF);
      end else begin
        hostWrite(a, d, 4'hF);
        hostRead($sformatf("alias read high %0d", i), aliasAddr, 4'hF);
      end
    end

    repeat (2) @(posedge clk);
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: memSelfTest.f
+incdir+hw
hw/memBusPkg.sv
hw/selfTestPkg.sv
hw/memWordIf.sv
hw/selfTestSequencer.sv
hw/unalignedSplitter.sv
hw/wordStore.sv
hw/readAligner.sv
hw/memSelfTest.sv
verification/memSelfTestTb.sv

// File: Bender.yml
package:
  name: memSelfTest

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/memBusPkg.sv
      - hw/selfTestPkg.sv
      - hw/memWordIf.sv
      - hw/selfTestSequencer.sv
      - hw/unalignedSplitter.sv
      - hw/wordStore.sv
      - hw/readAligner.sv
      - hw/memSelfTest.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/memSelfTestTb.sv
